//--- build.f
verilog/undo_pkg.sv
verilog/undo_log.sv
verilog/abort_sequencer.sv
verilog/undo_csr.sv
verilog/undo_unit_top.sv
tb/undo_mem_model.sv
tb/undo_unit_tb.sv

//--- Bender.yml
package:
  name: undo_unit

sources:
  - verilog/undo_pkg.sv
  - verilog/undo_log.sv
  - verilog/abort_sequencer.sv
  - verilog/undo_csr.sv
  - verilog/undo_unit_top.sv
  - target: simulation
    files:
      - tb/undo_mem_model.sv
      - tb/undo_unit_tb.sv

//--- tb/undo_unit_tb.sv
`default_nettype none

module undo_unit_tb import undo_pkg::*; ();

   localparam int wait_limit = 3000;

   typedef enum {
      op_log, op_log_all, op_abort, op_csr_wr, op_csr_rd,
      op_done, op_no_done, op_check, op_flood
   } op_e;

   typedef struct {
      op_e   kind;
      string name;
      int    slot;
      int    arg;
      int    core;
      int    value;
   } step_t;

   logic clk, rstn;
   logic [n_cores-1:0]              log_valid, log_ready;
   logic [n_cores-1:0][entry_w-1:0] log_id;
   logic [n_cores-1:0][addr_w-1:0]  log_addr;
   logic [n_cores-1:0][data_w-1:0]  log_data;
   logic [n_cores-1:0][slot_w-1:0]  log_slot;
   logic abort_req, abort_ack, done_req, done_ack;
   logic [slot_w-1:0] abort_slot, done_slot;
   logic csr_req, csr_we, csr_ack;
   logic [csr_addr_w-1:0] csr_addr;
   logic [csr_data_w-1:0] csr_wdata, csr_rdata;
   logic mem_wvalid, mem_wready, mem_bvalid, mem_bready;
   logic [addr_w-1:0] mem_waddr;
   logic [data_w-1:0] mem_wdata;
   logic [rthread_w-1:0] mem_wid, mem_bid;

   step_t steps[$];
   logic [addr_w-1:0] exp_addr [log_slots][entries_per_slot];
   logic [data_w-1:0] exp_data [log_slots][entries_per_slot];
   int exp_last [log_slots];
   int gen = 0;

   undo_unit_top undo_unit_top_inst (.*);

   // bready is not a top port
   assign mem_bready = (undo_unit_top_inst.undo_log_inst.ack_state == ack_idle);

   undo_mem_model mem_model_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s addr %h expected %h actual %h", name, addr, exp, act);
         abort_run("memory word wrong after restore");
      end
   endtask

   task automatic check_slot(input string name, input logic [slot_w-1:0] exp,
                             input logic [slot_w-1:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
         abort_run("unexpected completion slot");
      end
   endtask

   task automatic check_csr(input string name, input logic [csr_data_w-1:0] exp,
                            input logic [csr_data_w-1:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
         abort_run("register read wrong");
      end
   endtask

   task automatic check_ready(input string name, input logic [n_cores-1:0] exp,
                              input logic [n_cores-1:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         abort_run("wrong core granted the log");
      end
   endtask

   function automatic logic [addr_w-1:0] entry_addr(input int slot, input int id);
      return addr_w'(16'h4000 + slot * 64 + id * 4);
   endfunction

   function automatic logic [data_w-1:0] entry_data(input int slot, input int id, input int core);
      return {8'(8'hc0 + gen), 8'(slot), 8'(id), 8'(core)};
   endfunction

   task automatic drive_entry(input int core, input int slot, input int id);
      log_valid[core] = 1'b1;
      log_slot[core]  = slot_w'(slot);
      log_id[core]    = entry_w'(id);
      log_addr[core]  = entry_addr(slot, id);
      log_data[core]  = entry_data(slot, id, core);
      exp_addr[slot][id] = log_addr[core];
      exp_data[slot][id] = log_data[core];
      exp_last[slot] = id;   // restore walks up to the last id logged
   endtask

   task automatic log_entries(input int slot, input int n, input int core);
      int t;
      @(negedge clk);
      for (int id = 0; id < n; id++) begin
         drive_entry(core, slot, id);
         t = 0;
         do begin
            @(negedge clk);
            t++;
            if (t > wait_limit) abort_run("log entry was never accepted");
         end while (!log_ready[core]);
      end
      log_valid[core] = 1'b0;
      gen++;
   endtask

   task automatic log_all_cores(input string name, input int base, input int id);
      logic [n_cores-1:0] exp;
      @(negedge clk);
      for (int c = 0; c < n_cores; c++) drive_entry(c, base + c, id);
      // lowest valid core wins, one per cycle
      for (int c = 0; c < n_cores; c++) begin
         @(negedge clk);
         exp    = '0;
         exp[c] = 1'b1;
         check_ready(name, exp, log_ready);
         log_valid[c] = 1'b0;   // winner drops, losers hold
      end
      gen++;
   endtask

   task automatic wait_abort_ack(input int limit, output bit ok);
      int t;
      t  = 0;
      ok = abort_ack;
      while (!ok && t < limit) begin
         @(negedge clk);
         t++;
         ok = abort_ack;
      end
   endtask

   task automatic drop_abort();
      int t;
      abort_req = 1'b0;
      t = 0;
      while (abort_ack) begin
         @(negedge clk);
         t++;
         if (t > wait_limit) abort_run("abort_ack stayed high after req dropped");
      end
   endtask

   task automatic send_abort(input int slot);
      bit ok;
      @(negedge clk);
      abort_req  = 1'b1;
      abort_slot = slot_w'(slot);
      wait_abort_ack(wait_limit, ok);
      if (!ok) abort_run("abort_ack never rose");
      drop_abort();
   endtask

   // completions may come in any order, so they are matched against a set
   task automatic collect_done(input string name, inout logic [log_slots-1:0] left,
                               input int count);
      int t;
      logic [slot_w-1:0] exp;
      repeat (count) begin
         t = 0;
         while (!done_req) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) abort_run("done_req never rose");
         end
         exp = done_slot;
         if (!left[done_slot]) begin
            for (int s = log_slots - 1; s >= 0; s--) if (left[s]) exp = slot_w'(s);
         end
         check_slot(name, exp, done_slot);
         left[done_slot] = 1'b0;
         done_ack = 1'b1;
         t = 0;
         while (done_req) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) abort_run("done_req stayed high after ack");
         end
         done_ack = 1'b0;
      end
   endtask

   task automatic csr_access(input logic we, input int addr, input int wdata,
                             output logic [csr_data_w-1:0] rdata);
      int t;
      @(negedge clk);
      csr_req   = 1'b1;
      csr_we    = we;
      csr_addr  = csr_addr_w'(addr);
      csr_wdata = csr_data_w'(wdata);
      t = 0;
      while (!csr_ack) begin
         @(negedge clk);
         t++;
         if (t > wait_limit) abort_run("csr_ack never rose");
      end
      rdata   = csr_rdata;
      csr_req = 1'b0;
      t = 0;
      while (csr_ack) begin
         @(negedge clk);
         t++;
         if (t > wait_limit) abort_run("csr_ack stayed high after req dropped");
      end
      csr_we = 1'b0;
   endtask

   task automatic check_slot_mem(input string name, input int slot);
      logic [addr_w-1:0] a;
      for (int id = 0; id <= exp_last[slot]; id++) begin
         a = exp_addr[slot][id];
         check_word(name, a, exp_data[slot][id], mem_model_inst.shadow[a]);
      end
   endtask

   task automatic flood_aborts(input string name, input int n_ok, input int n_slots);
      bit ok;
      logic [log_slots-1:0] left;
      @(negedge clk);
      for (int i = 0; i < n_slots; i++) begin
         abort_req  = 1'b1;
         abort_slot = slot_w'(i);
         wait_abort_ack(i < n_ok ? 600 : 300, ok);
         if (i < n_ok) begin
            if (!ok) abort_run("abort_ack withheld before the queue was full");
            drop_abort();
         end else if (ok) begin
            abort_run("abort_ack given while queue and threads were full");
         end
      end
      left = '0;
      for (int i = 0; i < n_slots; i++) left[i] = 1'b1;
      collect_done(name, left, 1);
      wait_abort_ack(wait_limit, ok);
      if (!ok) abort_run("abort_ack did not return after a completion drained");
      drop_abort();
      collect_done(name, left, n_slots - 1);
   endtask

   task automatic add_step(input op_e k, input string n, input int s, input int a,
                           input int c, input int v);
      step_t st;
      st.kind  = k;
      st.name  = n;
      st.slot  = s;
      st.arg   = a;
      st.core  = c;
      st.value = v;
      steps.push_back(st);
   endtask

   task automatic build_table();
      add_step(op_log, "single_log", 2, 3, 1, 0);
      add_step(op_abort, "single_abort", 2, 0, 0, 0);
      add_step(op_done, "single_done", 0, 1, 0, 'h04);
      add_step(op_check, "single_mem", 2, 0, 0, 0);
      add_step(op_csr_wr, "clear_log_count", 0, csr_log_count, 0, 0);
      add_step(op_log_all, "arb_round0", 4, 0, 0, 0);
      add_step(op_log_all, "arb_round1", 4, 1, 0, 0);
      for (int s = 4; s < 8; s++) add_step(op_abort, "arb_abort", s, 0, 0, 0);
      add_step(op_done, "arb_done", 0, 4, 0, 'hf0);
      for (int s = 4; s < 8; s++) add_step(op_check, "arb_mem", s, 0, 0, 0);
      add_step(op_csr_rd, "arb_log_count", 0, csr_log_count, 0, 8);
      add_step(op_log, "overlap_log0", 0, 4, 2, 0);
      add_step(op_log, "overlap_log1", 1, 2, 3, 0);
      add_step(op_abort, "overlap_abort0", 0, 0, 0, 0);
      add_step(op_abort, "overlap_abort1", 1, 0, 0, 0);
      add_step(op_done, "overlap_done", 0, 2, 0, 'h03);
      add_step(op_check, "overlap_mem0", 0, 0, 0, 0);
      add_step(op_check, "overlap_mem1", 1, 0, 0, 0);
      add_step(op_csr_wr, "pause", 0, csr_ctrl, 0, 0);
      add_step(op_csr_rd, "pause_ctrl", 0, csr_ctrl, 0, 0);
      add_step(op_log, "pause_log", 3, 3, 0, 0);
      add_step(op_abort, "pause_abort", 3, 0, 0, 0);
      add_step(op_no_done, "pause_quiet", 0, 200, 0, 0);
      add_step(op_csr_wr, "resume", 0, csr_ctrl, 0, 1);
      add_step(op_done, "pause_done", 0, 1, 0, 'h08);
      add_step(op_check, "pause_mem", 3, 0, 0, 0);
      add_step(op_csr_wr, "clear_write_count", 0, csr_write_count, 0, 0);
      add_step(op_csr_wr, "clear_restore_count", 0, csr_restore_count, 0, 0);
      add_step(op_csr_rd, "write_count_zero", 0, csr_write_count, 0, 0);
      add_step(op_csr_rd, "restore_count_zero", 0, csr_restore_count, 0, 0);
      add_step(op_log, "count_log2", 2, 2, 1, 0);
      add_step(op_log, "count_log5", 5, 4, 0, 0);
      add_step(op_abort, "count_abort2", 2, 0, 0, 0);
      add_step(op_abort, "count_abort5", 5, 0, 0, 0);
      add_step(op_done, "count_done", 0, 2, 0, 'h24);
      add_step(op_csr_rd, "write_count", 0, csr_write_count, 0, 6);
      add_step(op_csr_rd, "restore_count", 0, csr_restore_count, 0, 2);
      for (int s = 0; s < 8; s++) add_step(op_log, "bp_log", s, s % 4 + 1, s % 4, 0);
      // one done pending, two busy threads, four queued
      add_step(op_flood, "bp_flood", 0, 7, 0, 8);
      for (int s = 0; s < 8; s++) add_step(op_check, "bp_mem", s, 0, 0, 0);
   endtask

   initial begin
      logic [csr_data_w-1:0] rd;
      logic [log_slots-1:0] left;
      rstn       = 1'b0;
      log_valid  = '0;
      log_id     = '0;
      log_addr   = '0;
      log_data   = '0;
      log_slot   = '0;
      abort_req  = 1'b0;
      abort_slot = '0;
      done_ack   = 1'b0;
      csr_req    = 1'b0;
      csr_we     = 1'b0;
      csr_addr   = '0;
      csr_wdata  = '0;
      build_table();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      foreach (steps[i]) begin
         case (steps[i].kind)
            op_log:     log_entries(steps[i].slot, steps[i].arg, steps[i].core);
            op_log_all: log_all_cores(steps[i].name, steps[i].slot, steps[i].arg);
            op_abort:   send_abort(steps[i].slot);
            op_csr_wr:  csr_access(1'b1, steps[i].arg, steps[i].value, rd);
            op_csr_rd: begin
               csr_access(1'b0, steps[i].arg, 0, rd);
               check_csr(steps[i].name, csr_data_w'(steps[i].value), rd);
            end
            op_done: begin
               left = log_slots'(steps[i].value);
               collect_done(steps[i].name, left, steps[i].arg);
            end
            op_no_done: begin
               for (int t = 0; t < steps[i].arg; t++) begin
                  @(negedge clk);
                  if (done_req) abort_run("done_req rose while restores were paused");
               end
            end
            op_check:   check_slot_mem(steps[i].name, steps[i].slot);
            op_flood:   flood_aborts(steps[i].name, steps[i].arg, steps[i].value);
            default:    abort_run("unknown step kind in table");
         endcase
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/undo_mem_model.sv
`default_nettype none

module undo_mem_model import undo_pkg::*; (
   input  wire                 clk,
   input  wire                 rstn,
   input  wire                 mem_wvalid,
   input  wire [addr_w-1:0]    mem_waddr,
   input  wire [data_w-1:0]    mem_wdata,
   input  wire [rthread_w-1:0] mem_wid,
   output logic                mem_wready,
   output logic                mem_bvalid,
   output logic [rthread_w-1:0] mem_bid,
   input  wire                 mem_bready
);

   logic [data_w-1:0] shadow [1 << addr_w];
   logic [rthread_w-1:0] pend [$];   // one global queue keeps per-thread order
   int seed = 32'h6085_37aa;
   bit b_taken;

   initial begin
      for (int a = 0; a < (1 << addr_w); a++) shadow[a] = {~a[15:0], a[15:0]};
      mem_wready = 1'b0;
      mem_bvalid = 1'b0;
      mem_bid    = '0;
      b_taken    = 1'b0;
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (mem_wvalid && mem_wready) begin
            shadow[mem_waddr] = mem_wdata;
            pend.push_back(mem_wid);
         end
         if (mem_bvalid && mem_bready) begin
            void'(pend.pop_front());
            b_taken = 1'b1;
         end
      end
   end

   // random stalls and response delays, driven away from the rising edge
   always @(negedge clk) begin
      if (!rstn) begin
         mem_wready = 1'b0;
         mem_bvalid = 1'b0;
      end else begin
         mem_wready = ($random(seed) & 3) != 0;
         if (b_taken || !mem_bvalid) begin
            b_taken    = 1'b0;
            mem_bvalid = (pend.size() > 0) && ($random(seed) & 1);
            if (mem_bvalid) mem_bid = pend[0];
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/undo_unit_top.sv
`default_nettype none

module undo_unit_top import undo_pkg::*; (
   input  wire                              clk,
   input  wire                              rstn,

   input  wire  [n_cores-1:0]               log_valid,
   input  wire  [n_cores-1:0][entry_w-1:0]  log_id,
   input  wire  [n_cores-1:0][addr_w-1:0]   log_addr,
   input  wire  [n_cores-1:0][data_w-1:0]   log_data,
   input  wire  [n_cores-1:0][slot_w-1:0]   log_slot,
   output logic [n_cores-1:0]               log_ready,

   input  wire                              abort_req,
   input  wire  [slot_w-1:0]                abort_slot,
   output logic                             abort_ack,

   output logic                             done_req,
   output logic [slot_w-1:0]                done_slot,
   input  wire                              done_ack,

   input  wire                              csr_req,
   input  wire                              csr_we,
   input  wire  [csr_addr_w-1:0]            csr_addr,
   input  wire  [csr_data_w-1:0]            csr_wdata,
   output logic                             csr_ack,
   output logic [csr_data_w-1:0]            csr_rdata,

   output logic                             mem_wvalid,
   output logic [addr_w-1:0]                mem_waddr,
   output logic [data_w-1:0]                mem_wdata,
   output logic [rthread_w-1:0]             mem_wid,
   input  wire                              mem_wready,
   input  wire                              mem_bvalid,
   input  wire  [rthread_w-1:0]             mem_bid
);

   logic [n_restore_threads-1:0]              restore_arvalid, restore_rvalid;
   logic [slot_w-1:0]                         restore_slot;
   logic [n_restore_threads-1:0]              restore_done_valid, restore_done_ready;
   logic [n_restore_threads-1:0][slot_w-1:0]  restore_done_slot;
   logic restore_enable;
   logic log_accept_pulse, write_issue_pulse, restore_done_pulse;

   undo_log undo_log_inst (
      .clk, .rstn,
      .log_valid, .log_id, .log_addr, .log_data, .log_slot, .log_ready,
      .restore_arvalid, .restore_rvalid, .restore_slot,
      .restore_done_valid, .restore_done_slot, .restore_done_ready,
      .mem_wvalid, .mem_waddr, .mem_wdata, .mem_wid,
      .mem_wready, .mem_bvalid, .mem_bid,
      .restore_enable, .log_accept_pulse, .write_issue_pulse
   );

   // stands in for the conflict serializer
   abort_sequencer abort_sequencer_inst (
      .clk, .rstn,
      .abort_req, .abort_slot, .abort_ack,
      .restore_arvalid, .restore_rvalid, .restore_slot,
      .restore_done_valid, .restore_done_slot, .restore_done_ready,
      .done_req, .done_slot, .done_ack,
      .restore_done_pulse
   );

   undo_csr undo_csr_inst (
      .clk, .rstn,
      .csr_req, .csr_we, .csr_addr, .csr_wdata, .csr_ack, .csr_rdata,
      .restore_enable,
      .log_accept_pulse, .write_issue_pulse, .restore_done_pulse
   );

endmodule

`default_nettype wire

//--- verilog/undo_csr.sv
`default_nettype none

module undo_csr import undo_pkg::*; (
   input  wire                   clk,
   input  wire                   rstn,

   input  wire                   csr_req,
   input  wire                   csr_we,
   input  wire  [csr_addr_w-1:0] csr_addr,
   input  wire  [csr_data_w-1:0] csr_wdata,
   output logic                  csr_ack,
   output logic [csr_data_w-1:0] csr_rdata,

   output logic                  restore_enable,

   input  wire                   log_accept_pulse,
   input  wire                   write_issue_pulse,
   input  wire                   restore_done_pulse
);

   hs_state_e st;
   csr_reg_e  reg_sel;
   logic      access;
   logic [3:1] events;
   logic [csr_data_w-1:0] cnt [1:3];   // indexed by register address

   assign reg_sel = csr_reg_e'(csr_addr);
   assign access  = (st == hs_idle) && csr_req;
   assign csr_ack = (st == hs_wait_drop);
   assign events  = {restore_done_pulse, write_issue_pulse, log_accept_pulse};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         st             <= hs_idle;
         restore_enable <= 1'b1;
         for (int k = 1; k <= 3; k++) cnt[k] <= '0;
      end else begin
         if (st == hs_idle) begin
            if (csr_req) st <= hs_wait_drop;
         end else if (!csr_req) begin
            st <= hs_idle;
         end

         if (access && csr_we && reg_sel == csr_ctrl) restore_enable <= csr_wdata[0];

         // saturating, any write clears
         for (int k = 1; k <= 3; k++) begin
            if (access && csr_we && csr_addr == csr_addr_w'(k)) begin
               cnt[k] <= '0;
            end else if (events[k] && cnt[k] != '1) begin
               cnt[k] <= cnt[k] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_sel)
            csr_ctrl:          csr_rdata <= {{(csr_data_w - 1){1'b0}}, restore_enable};
            csr_log_count:     csr_rdata <= cnt[1];
            csr_write_count:   csr_rdata <= cnt[2];
            csr_restore_count: csr_rdata <= cnt[3];
            default:           csr_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/abort_sequencer.sv
`default_nettype none

module abort_sequencer import undo_pkg::*; (
   input  wire                                       clk,
   input  wire                                       rstn,

   input  wire                                       abort_req,
   input  wire  [slot_w-1:0]                         abort_slot,
   output logic                                      abort_ack,

   input  wire  [n_restore_threads-1:0]              restore_arvalid,
   output logic [n_restore_threads-1:0]              restore_rvalid,
   output logic [slot_w-1:0]                         restore_slot,

   input  wire  [n_restore_threads-1:0]              restore_done_valid,
   input  wire  [n_restore_threads-1:0][slot_w-1:0]  restore_done_slot,
   output logic [n_restore_threads-1:0]              restore_done_ready,

   output logic                                      done_req,
   output logic [slot_w-1:0]                         done_slot,
   input  wire                                       done_ack,

   output logic                                      restore_done_pulse
);

   logic [slot_w-1:0] q_mem [abort_q_depth];
   logic [$clog2(abort_q_depth)-1:0] q_wr, q_rd;
   logic [$clog2(abort_q_depth):0]   q_count;
   logic push, pop, q_full, q_empty;

   hs_state_e ab_state, dn_state;
   logic [rthread_w-1:0] gthread, dsel;
   logic done_take;

   assign q_full  = (q_count == abort_q_depth);
   assign q_empty = (q_count == 0);
   assign push    = (ab_state == hs_idle) && abort_req && !q_full;   // enqueue point
   assign pop     = (|restore_arvalid) && !q_empty && (restore_rvalid == '0);

   assign abort_ack = (ab_state == hs_wait_drop);
   assign done_req  = (dn_state == hs_wait_drop);

   always_comb begin
      gthread = '0;
      dsel    = '0;
      for (int i = n_restore_threads - 1; i >= 0; i--) begin
         if (restore_arvalid[i]) gthread = rthread_w'(i);
         if (restore_done_valid[i]) dsel = rthread_w'(i);
      end
   end

   // no new completion while one is pending or ack still high
   always_comb begin
      for (int i = 0; i < n_restore_threads; i++) begin
         restore_done_ready[i] = (dn_state == hs_idle) && !done_ack && (dsel == rthread_w'(i));
      end
   end

   assign done_take = |(restore_done_valid & restore_done_ready);

   always_ff @(posedge clk) begin
      if (push) q_mem[q_wr] <= abort_slot;
      if (pop) restore_slot <= q_mem[q_rd];
      if (done_take) done_slot <= restore_done_slot[dsel];
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         q_wr               <= '0;
         q_rd               <= '0;
         q_count            <= '0;
         ab_state           <= hs_idle;
         dn_state           <= hs_idle;
         restore_rvalid     <= '0;
         restore_done_pulse <= 1'b0;
      end else begin
         if (push) q_wr <= q_wr + 1'b1;
         if (pop) q_rd <= q_rd + 1'b1;
         q_count <= q_count + push - pop;

         restore_rvalid <= '0;
         if (pop) restore_rvalid[gthread] <= 1'b1;

         if (ab_state == hs_idle) begin
            if (push) ab_state <= hs_wait_drop;
         end else if (!abort_req) begin
            ab_state <= hs_idle;
         end

         if (dn_state == hs_idle) begin
            if (done_take) dn_state <= hs_wait_drop;
         end else if (done_ack) begin
            dn_state <= hs_idle;
         end
         restore_done_pulse <= done_take;
      end
   end

endmodule

`default_nettype wire

//--- verilog/undo_log.sv
`default_nettype none

module undo_log import undo_pkg::*; (
   input  wire                                          clk,
   input  wire                                          rstn,

   input  wire  [n_cores-1:0]                           log_valid,
   input  wire  [n_cores-1:0][entry_w-1:0]              log_id,
   input  wire  [n_cores-1:0][addr_w-1:0]               log_addr,
   input  wire  [n_cores-1:0][data_w-1:0]               log_data,
   input  wire  [n_cores-1:0][slot_w-1:0]               log_slot,
   output logic [n_cores-1:0]                           log_ready,

   output logic [n_restore_threads-1:0]                 restore_arvalid,
   input  wire  [n_restore_threads-1:0]                 restore_rvalid,
   input  wire  [slot_w-1:0]                            restore_slot,

   output logic [n_restore_threads-1:0]                 restore_done_valid,
   output logic [n_restore_threads-1:0][slot_w-1:0]     restore_done_slot,
   input  wire  [n_restore_threads-1:0]                 restore_done_ready,

   output logic                                         mem_wvalid,
   output logic [addr_w-1:0]                            mem_waddr,
   output logic [data_w-1:0]                            mem_wdata,
   output logic [rthread_w-1:0]                         mem_wid,
   input  wire                                          mem_wready,
   input  wire                                          mem_bvalid,
   input  wire  [rthread_w-1:0]                         mem_bid,

   input  wire                                          restore_enable,
   output logic                                         log_accept_pulse,
   output logic                                         write_issue_pulse
);

   logic [core_w-1:0]    sel_core;
   logic                 sel_valid;
   logic [log_idx_w-1:0] wr_idx;

   logic [addr_w-1:0]  addr_mem [log_depth];
   logic [data_w-1:0]  data_mem [log_depth];
   logic [entry_w-1:0] last_id  [log_slots];

   logic [addr_w-1:0] addr_rd;
   logic [data_w-1:0] data_rd;

   restore_state_e rs_state;
   ack_state_e     ack_state;

   logic [n_restore_threads-1:0]              thread_busy;
   logic [n_restore_threads-1:0][slot_w-1:0]  thread_slot;
   logic [n_restore_threads-1:0][entry_w:0]   outstanding;
   logic [rthread_w-1:0] arthread, rthread, wthread, ack_thread;

   logic [slot_w-1:0]  cur_slot;
   logic [entry_w-1:0] cur_id;
   logic grant, issue, b_take, done_take;

   // lowest-numbered valid core wins
   always_comb begin
      sel_core = '0;
      for (int i = n_cores - 1; i >= 0; i--) begin
         if (log_valid[i]) sel_core = core_w'(i);
      end
   end

   assign sel_valid = |log_valid;
   assign wr_idx    = {log_slot[sel_core], log_id[sel_core]};

   always_comb begin
      for (int i = 0; i < n_cores; i++) begin
         log_ready[i] = sel_valid && (sel_core == core_w'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (sel_valid) begin
         addr_mem[wr_idx]            <= log_addr[sel_core];
         data_mem[wr_idx]            <= log_data[sel_core];
         last_id[log_slot[sel_core]] <= log_id[sel_core];
      end
      if (rs_state == restore_read_log) begin
         addr_rd <= addr_mem[{cur_slot, cur_id}];
         data_rd <= data_mem[{cur_slot, cur_id}];
      end
   end

   // lowest free thread asks for work
   always_comb begin
      arthread = '0;
      for (int i = n_restore_threads - 1; i >= 0; i--) begin
         if (!thread_busy[i]) arthread = rthread_w'(i);
      end
   end

   always_comb begin
      for (int i = 0; i < n_restore_threads; i++) begin
         restore_arvalid[i] = restore_enable && (rs_state == restore_idle)
            && !thread_busy[i] && (arthread == rthread_w'(i)) && !restore_rvalid[rthread];
         restore_done_valid[i] = (ack_state == ack_received) && (ack_thread == rthread_w'(i));
      end
   end

   assign restore_done_slot = thread_slot;

   assign grant     = (rs_state == restore_idle) && restore_rvalid[rthread];
   assign issue     = mem_wvalid && mem_wready;
   assign b_take    = mem_bvalid && (ack_state == ack_idle);
   assign done_take = (ack_state == ack_received) && restore_done_ready[ack_thread];

   always_ff @(posedge clk) begin
      rthread <= arthread;   // answer comes a cycle after the ask
      if (grant) begin
         cur_slot             <= restore_slot;
         cur_id               <= '0;
         wthread              <= rthread;
         thread_slot[rthread] <= restore_slot;
      end else if (issue) begin
         cur_id <= cur_id + 1'b1;
      end
      if (b_take && outstanding[mem_bid] == 1) ack_thread <= mem_bid;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rs_state <= restore_idle;
      end else begin
         case (rs_state)
            restore_idle: if (grant) rs_state <= restore_read_log;
            restore_read_log: rs_state <= restore_write_mem;
            restore_write_mem: begin
               if (issue) begin
                  rs_state <= (cur_id < last_id[cur_slot]) ? restore_read_log : restore_idle;
               end
            end
            default: rs_state <= restore_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ack_state <= ack_idle;
      end else if (ack_state == ack_idle) begin
         if (b_take && outstanding[mem_bid] == 1) ack_state <= ack_received;
      end else if (done_take) begin
         ack_state <= ack_idle;
      end
   end

   // responses still owed per thread
   always_ff @(posedge clk) begin
      if (!rstn) begin
         thread_busy <= '0;
         outstanding <= '0;
      end else begin
         for (int i = 0; i < n_restore_threads; i++) begin
            if (grant && rthread == rthread_w'(i)) begin
               thread_busy[i] <= 1'b1;
               outstanding[i] <= {1'b0, last_id[restore_slot]} + 1'b1;
            end else if (b_take && mem_bid == rthread_w'(i)) begin
               outstanding[i] <= outstanding[i] - 1'b1;
            end
            if (done_take && ack_thread == rthread_w'(i)) thread_busy[i] <= 1'b0;
         end
      end
   end

   assign mem_wvalid = (rs_state == restore_write_mem);
   assign mem_waddr  = addr_rd;
   assign mem_wdata  = data_rd;
   assign mem_wid    = wthread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         log_accept_pulse  <= 1'b0;
         write_issue_pulse <= 1'b0;
      end else begin
         log_accept_pulse  <= sel_valid;
         write_issue_pulse <= issue;
      end
   end

endmodule

`default_nettype wire

//--- verilog/undo_pkg.sv
`default_nettype none

package undo_pkg;

   // sizes
   localparam int n_cores           = 4;
   localparam int n_restore_threads = 2;
   localparam int log_slots         = 8;
   localparam int entries_per_slot  = 4;
   localparam int abort_q_depth     = 4;

   // widths
   localparam int slot_w     = 3;
   localparam int entry_w    = 2;
   localparam int core_w     = 2;
   localparam int rthread_w  = 1;
   localparam int addr_w     = 16;
   localparam int data_w     = 32;
   localparam int csr_addr_w = 2;
   localparam int csr_data_w = 16;

   // log storage index is {slot, entry}
   localparam int log_idx_w = slot_w + entry_w;
   localparam int log_depth = log_slots * entries_per_slot;

   typedef enum logic [1:0] {
      restore_idle,
      restore_read_log,
      restore_write_mem
   } restore_state_e;

   typedef enum logic {
      ack_idle,
      ack_received
   } ack_state_e;

   // four-phase phase tracker
   typedef enum logic {
      hs_idle,
      hs_wait_drop
   } hs_state_e;

   typedef enum logic [1:0] {
      csr_ctrl          = 2'd0,
      csr_log_count     = 2'd1,
      csr_write_count   = 2'd2,
      csr_restore_count = 2'd3
   } csr_reg_e;

endpackage

`default_nettype wire
